// File: hw/laser_consts.svh
`ifndef LASER_CONSTS_SVH
`define LASER_CONSTS_SVH

// Clock cycles spent on each laser bit
`define BIT_CYCLES 8

// Start bit, eight data bits, stop bit
`define FRAME_BITS 10

// Phases inside a bit where the receiver samples for the vote
`define VOTE_FIRST 3
`define VOTE_LAST 5

// Bytes held by the receive queue, a power of two
`define QUEUE_DEPTH 16

`endif

// File: hw/laser_pkg.sv
`default_nettype none
`include "laser_consts.svh"

package laser_pkg;

    // Cycle position inside one laser bit
    typedef logic [$clog2(`BIT_CYCLES)-1:0] bit_phase_t;

    // Bit position inside one frame
    typedef logic [$clog2(`FRAME_BITS)-1:0] bit_index_t;

    // Shift image of a received frame, start bit at index 0
    typedef logic [`FRAME_BITS-1:0] frame_t;

endpackage

`default_nettype wire

// File: hw/link_pkg.sv
`default_nettype none
`include "laser_consts.svh"

package link_pkg;

    typedef logic [7:0] byte_t;

    // Controller states, FTDI reads first, then send, or a queue write
    typedef enum logic [2:0] {
        IDLE,
        READ_FIRST,
        WAIT_SECOND,
        READ_SECOND,
        SEND,
        WRITE_SETUP,
        WRITE
    } link_state_t;

    // Fill level, one bit wider than the queue address
    typedef logic [$clog2(`QUEUE_DEPTH):0] queue_count_t;

endpackage

`default_nettype wire

// File: hw/bit_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "laser_consts.svh"

module bit_timer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  run,
    output laser_pkg::bit_phase_t phase,
    output laser_pkg::bit_index_t bit_index,
    output logic                  bit_end,
    output logic                  frame_end
);
    import laser_pkg::*;

    localparam bit_phase_t LAST_PHASE = bit_phase_t'(`BIT_CYCLES - 1);
    localparam bit_index_t LAST_BIT = bit_index_t'(`FRAME_BITS - 1);

    assign bit_end = run && (phase == LAST_PHASE);
    assign frame_end = bit_end && (bit_index == LAST_BIT);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= '0;
            bit_index <= '0;
        end else if (!run) begin
            // Idle timer sits at the start of bit 0
            phase <= '0;
            bit_index <= '0;
        end else if (bit_end) begin
            phase <= '0;
            bit_index <= frame_end ? '0 : bit_index + 1'b1;
        end else begin
            phase <= phase + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/laser_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module laser_serializer (
    input  logic            clock,
    input  logic            reset,
    input  logic            send_start,
    input  link_pkg::byte_t send_byte1,
    input  link_pkg::byte_t send_byte2,
    output logic            laser1_tx,
    output logic            laser2_tx,
    output logic            send_done
);
    import link_pkg::*;
    import laser_pkg::*;

    logic       busy;
    byte_t      byte1_q;
    byte_t      byte2_q;
    frame_t     frame1;
    frame_t     frame2;
    bit_index_t bit_index;
    logic       frame_end;

    bit_timer u_timer (
        .clock     (clock),
        .reset     (reset),
        .run       (busy),
        .phase     (),
        .bit_index (bit_index),
        .bit_end   (),
        .frame_end (frame_end)
    );

    // Low stop bit on top, high start bit at the bottom so index 0 goes out first
    assign frame1 = {1'b0, byte1_q, 1'b1};
    assign frame2 = {1'b0, byte2_q, 1'b1};

    // Both lanes step through the same bit index
    assign laser1_tx = busy && frame1[bit_index];
    assign laser2_tx = busy && frame2[bit_index];

    assign send_done = frame_end;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (send_start) begin
            busy <= 1'b1;
        end else if (frame_end) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (send_start) begin
            byte1_q <= send_byte1;
            byte2_q <= send_byte2;
        end
    end

    // Controller must wait for send_done before the next pair
    start_while_busy: assert property (
        @(posedge clock) disable iff (reset) send_start |-> !busy
    ) else $error("send_start during an active frame");

endmodule

`default_nettype wire

// File: hw/laser_deserializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "laser_consts.svh"

module laser_deserializer (
    input  logic            clock,
    input  logic            reset,
    input  logic            laser1_rx,
    input  logic            laser2_rx,
    output logic            rx_valid,
    output link_pkg::byte_t rx_byte1,
    output link_pkg::byte_t rx_byte2
);
    import laser_pkg::*;

    localparam bit_phase_t VOTE_LO = bit_phase_t'(`VOTE_FIRST);
    localparam bit_phase_t VOTE_HI = bit_phase_t'(`VOTE_LAST);

    logic [1:0] sync1;
    logic [1:0] sync2;
    logic       prev1;
    logic       prev2;
    logic       start_edge;
    logic       busy;
    logic       in_vote;
    logic [1:0] votes1;
    logic [1:0] votes2;
    frame_t     frame1;
    frame_t     frame2;
    frame_t     next1;
    frame_t     next2;
    logic       frame_ok;
    bit_phase_t phase;
    logic       bit_end;
    logic       frame_end;

    bit_timer u_timer (
        .clock     (clock),
        .reset     (reset),
        .run       (busy),
        .phase     (phase),
        .bit_index (),
        .bit_end   (bit_end),
        .frame_end (frame_end)
    );

    // Two flops per lane, then one more to find the rising edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync1 <= '0;
            sync2 <= '0;
            prev1 <= 1'b0;
            prev2 <= 1'b0;
        end else begin
            sync1 <= {sync1[0], laser1_rx};
            sync2 <= {sync2[0], laser2_rx};
            prev1 <= sync1[1];
            prev2 <= sync2[1];
        end
    end

    assign start_edge = (sync1[1] && !prev1) || (sync2[1] && !prev2);
    assign in_vote = busy && (phase >= VOTE_LO) && (phase <= VOTE_HI);

    // Majority of three is simply the top bit of the count
    assign next1 = {votes1[1], frame1[`FRAME_BITS-1:1]};
    assign next2 = {votes2[1], frame2[`FRAME_BITS-1:1]};

    assign frame_ok = next1[0] && !next1[`FRAME_BITS-1] && next2[0] && !next2[`FRAME_BITS-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            votes1 <= '0;
            votes2 <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (!busy) begin
                busy <= start_edge;
            end else if (frame_end) begin
                busy <= 1'b0;
            end
            if (!busy || bit_end) begin
                votes1 <= '0;
                votes2 <= '0;
            end else if (in_vote) begin
                votes1 <= votes1 + {1'b0, sync1[1]};
                votes2 <= votes2 + {1'b0, sync2[1]};
            end
            // Bad start or stop on either lane drops the whole pair
            rx_valid <= frame_end && frame_ok;
        end
    end

    always_ff @(posedge clock) begin
        if (bit_end) begin
            frame1 <= next1;
            frame2 <= next2;
        end
    end

    assign rx_byte1 = frame1[`FRAME_BITS-2:1];
    assign rx_byte2 = frame2[`FRAME_BITS-2:1];

endmodule

`default_nettype wire

// File: hw/rx_byte_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "laser_consts.svh"

module rx_byte_queue (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   push,
    input  link_pkg::byte_t        push_byte1,
    input  link_pkg::byte_t        push_byte2,
    input  logic                   pop,
    output link_pkg::byte_t        head,
    output logic                   empty,
    output link_pkg::queue_count_t count
);
    import link_pkg::*;

    localparam int ADDR_W = $clog2(`QUEUE_DEPTH);
    localparam queue_count_t PAIR_LIMIT = queue_count_t'(`QUEUE_DEPTH - 2);

    byte_t             mem [`QUEUE_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] wr_ptr_next;
    logic [ADDR_W-1:0] rd_ptr;

    // Pointers wrap on their own since the depth is a power of two
    assign wr_ptr_next = wr_ptr + 1'b1;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_byte1;
            mem[wr_ptr_next] <= push_byte2;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd2;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (push ? queue_count_t'(2) : '0) - (pop ? queue_count_t'(1) : '0);
        end
    end

    assign head = mem[rd_ptr];
    assign empty = (count == '0);

    // Upstream has no back-pressure, so the controller must keep room for a pair
    no_overflow: assert property (
        @(posedge clock) disable iff (reset) push |-> count <= PAIR_LIMIT
    ) else $error("queue push with fewer than two free slots");

    no_underflow: assert property (
        @(posedge clock) disable iff (reset) pop |-> !empty
    ) else $error("queue pop while empty");

endmodule

`default_nettype wire

// File: hw/link_controller.sv
`timescale 1ns/1ps
`default_nettype none

module link_controller (
    input  logic            clock,
    input  logic            reset,
    input  logic            rxf,
    input  logic            txe,
    input  link_pkg::byte_t adbus_in,
    input  logic            send_done,
    input  link_pkg::byte_t queue_head,
    input  logic            queue_empty,
    output logic            ftdi_rd,
    output logic            ftdi_wr,
    output link_pkg::byte_t adbus_out,
    output logic            adbus_oe,
    output logic            send_start,
    output link_pkg::byte_t send_byte1,
    output link_pkg::byte_t send_byte2,
    output logic            queue_pop
);
    import link_pkg::*;

    link_state_t state;
    link_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Draining wins over a new read
                if (!queue_empty && !txe) begin
                    state_next = WRITE_SETUP;
                end else if (!rxf) begin
                    state_next = READ_FIRST;
                end
            end
            READ_FIRST: state_next = WAIT_SECOND;
            WAIT_SECOND: begin
                if (!rxf) begin
                    state_next = READ_SECOND;
                end
            end
            READ_SECOND: state_next = SEND;
            SEND: begin
                if (send_done) begin
                    state_next = IDLE;
                end
            end
            // FTDI went full in the meantime, back off
            WRITE_SETUP: state_next = txe ? IDLE : WRITE;
            WRITE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            send_start <= 1'b0;
        end else begin
            state <= state_next;
            // High in the first SEND cycle only
            send_start <= (state == READ_SECOND);
        end
    end

    // Byte is on the bus at the end of the read strobe cycle
    always_ff @(posedge clock) begin
        if (state == READ_FIRST) begin
            send_byte1 <= adbus_in;
        end
        if (state == READ_SECOND) begin
            send_byte2 <= adbus_in;
        end
    end

    assign ftdi_rd = !((state == READ_FIRST) || (state == READ_SECOND));
    assign ftdi_wr = (state != WRITE);
    assign adbus_oe = (state == WRITE_SETUP) || (state == WRITE);
    assign queue_pop = (state == WRITE);

    // Head stays put until the pop at the end of WRITE
    assign adbus_out = adbus_oe ? queue_head : '0;

    rd_wr_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(!ftdi_rd && !ftdi_wr)
    ) else $error("ftdi_rd and ftdi_wr low together");

    rd_needs_data: assert property (
        @(posedge clock) disable iff (reset) !ftdi_rd |-> !rxf
    ) else $error("ftdi_rd strobe while the FTDI FIFO is empty");

endmodule

`default_nettype wire

// File: hw/laser_link.sv
`timescale 1ns/1ps
`default_nettype none

module laser_link (
    input  logic            clock,
    input  logic            reset,
    input  logic            rxf,
    input  logic            txe,
    input  link_pkg::byte_t adbus_in,
    output logic            ftdi_rd,
    output logic            ftdi_wr,
    output link_pkg::byte_t adbus_out,
    output logic            adbus_oe,
    output logic            laser1_tx,
    output logic            laser2_tx,
    input  logic            laser1_rx,
    input  logic            laser2_rx
);
    import link_pkg::*;

    logic  send_start;
    byte_t send_byte1;
    byte_t send_byte2;
    logic  send_done;
    logic  rx_valid;
    byte_t rx_byte1;
    byte_t rx_byte2;
    logic  queue_pop;
    byte_t queue_head;
    logic  queue_empty;

    link_controller u_controller (
        .clock       (clock),
        .reset       (reset),
        .rxf         (rxf),
        .txe         (txe),
        .adbus_in    (adbus_in),
        .send_done   (send_done),
        .queue_head  (queue_head),
        .queue_empty (queue_empty),
        .ftdi_rd     (ftdi_rd),
        .ftdi_wr     (ftdi_wr),
        .adbus_out   (adbus_out),
        .adbus_oe    (adbus_oe),
        .send_start  (send_start),
        .send_byte1  (send_byte1),
        .send_byte2  (send_byte2),
        .queue_pop   (queue_pop)
    );

    laser_serializer u_serializer (
        .clock      (clock),
        .reset      (reset),
        .send_start (send_start),
        .send_byte1 (send_byte1),
        .send_byte2 (send_byte2),
        .laser1_tx  (laser1_tx),
        .laser2_tx  (laser2_tx),
        .send_done  (send_done)
    );

    laser_deserializer u_deserializer (
        .clock     (clock),
        .reset     (reset),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .rx_valid  (rx_valid),
        .rx_byte1  (rx_byte1),
        .rx_byte2  (rx_byte2)
    );

    // Received pairs go straight into the queue, lane 1 first
    rx_byte_queue u_queue (
        .clock      (clock),
        .reset      (reset),
        .push       (rx_valid),
        .push_byte1 (rx_byte1),
        .push_byte2 (rx_byte2),
        .pop        (queue_pop),
        .head       (queue_head),
        .empty      (queue_empty),
        .count      ()
    );

endmodule

`default_nettype wire

// File: test/laser_link_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "laser_consts.svh"

module laser_link_tb;
    import link_pkg::*;

    // Cycles allowed per expected byte before a wait gives up
    localparam int BYTE_TIMEOUT = 300;

    logic   clock;
    logic   reset;
    logic   rxf;
    logic   txe;
    byte_t  adbus_in;
    logic   ftdi_rd;
    logic   ftdi_wr;
    byte_t  adbus_out;
    logic   adbus_oe;
    logic   laser1_tx;
    logic   laser2_tx;
    logic   laser1_rx;
    logic   laser2_rx;

    byte_t  read_q[$];
    byte_t  written[$];
    byte_t  expected[$];
    logic   pop_due;
    logic   wr_setup;
    byte_t  setup_byte;
    logic   txe_hold;
    logic   loopback;
    logic   drive1;
    logic   drive2;
    integer seed;

    laser_link UUT (
        .clock     (clock),
        .reset     (reset),
        .rxf       (rxf),
        .txe       (txe),
        .adbus_in  (adbus_in),
        .ftdi_rd   (ftdi_rd),
        .ftdi_wr   (ftdi_wr),
        .adbus_out (adbus_out),
        .adbus_oe  (adbus_oe),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t want);
        if (got !== want) begin
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    // FTDI model, strobes sampled mid cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (!ftdi_rd) begin
                if (read_q.size() == 0) begin
                    report_failure("ftdi_rd strobe while the FTDI read FIFO is empty");
                end
                pop_due = 1'b1;
            end
            if (!ftdi_wr) begin
                if (txe) begin
                    report_failure("ftdi_wr strobe while txe is high");
                end
                if (!wr_setup) begin
                    report_failure("ftdi_wr strobe without a setup cycle on adbus_oe");
                end
                compare_bit("adbus_oe", adbus_oe, 1'b1);
                compare_byte("adbus_out", adbus_out, setup_byte);
                written.push_back(adbus_out);
            end
            wr_setup = adbus_oe && ftdi_wr;
            setup_byte = adbus_out;
        end
    end

    // Pop lands on the edge that ends the read strobe
    always @(posedge clock) begin
        #2;
        if (pop_due) begin
            read_q.delete(0);
            pop_due = 1'b0;
        end
        rxf = (read_q.size() == 0);
        adbus_in = rxf ? 8'h00 : read_q[0];
        txe = txe_hold;
    end

    // Laser selector
    always @(posedge clock) begin
        #2;
        laser1_rx = loopback ? laser1_tx : drive1;
        laser2_rx = loopback ? laser2_tx : drive2;
    end

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    task automatic wait_reads_done();
        int cycles;
        cycles = 0;
        while (read_q.size() != 0) begin
            if (cycles == BYTE_TIMEOUT * 4) begin
                report_failure("timeout: the DUT stopped reading the FTDI FIFO");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic check_written();
        int cycles;
        cycles = 0;
        while (written.size() < expected.size()) begin
            if (cycles == BYTE_TIMEOUT * expected.size()) begin
                report_failure($sformatf("timeout: %0d of %0d bytes reached the FTDI side",
                                         written.size(), expected.size()));
            end
            @(negedge clock);
            cycles++;
        end
        // Room for a duplicate to show up
        idle_cycles(20);
        if (written.size() != expected.size()) begin
            report_failure($sformatf("%0d bytes written on the FTDI side, %0d expected",
                                     written.size(), expected.size()));
        end
        foreach (expected[i]) begin
            compare_byte($sformatf("adbus_out byte %0d", i), written[i], expected[i]);
        end
        written.delete();
        expected.delete();
    endtask

    task automatic load_pair(input byte_t byte1, input byte_t byte2);
        @(negedge clock);
        read_q.push_back(byte1);
        read_q.push_back(byte2);
        expected.push_back(byte1);
        expected.push_back(byte2);
    endtask

    // Start high, data LSB first, then the stop bit
    function automatic logic frame_bit(input byte_t data, input int index, input logic stop);
        if (index == 0) begin
            return 1'b1;
        end
        if (index == `FRAME_BITS - 1) begin
            return stop;
        end
        return data[index - 1];
    endfunction

    // One sample per cycle, the sample at bad_phase of every bit inverted
    task automatic drive_frames(input byte_t byte1, input byte_t byte2, input logic stop2,
                                input int bad_phase);
        for (int bit_pos = 0; bit_pos < `FRAME_BITS; bit_pos++) begin
            for (int phase = 0; phase < `BIT_CYCLES; phase++) begin
                @(negedge clock);
                drive1 = frame_bit(byte1, bit_pos, 1'b0) ^ (phase == bad_phase);
                drive2 = frame_bit(byte2, bit_pos, stop2) ^ (phase == bad_phase);
            end
        end
        @(negedge clock);
        drive1 = 1'b0;
        drive2 = 1'b0;
        idle_cycles(4);
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        compare_bit("ftdi_rd", ftdi_rd, 1'b1);
        compare_bit("ftdi_wr", ftdi_wr, 1'b1);
        compare_bit("adbus_oe", adbus_oe, 1'b0);
        compare_bit("laser1_tx", laser1_tx, 1'b0);
        compare_bit("laser2_tx", laser2_tx, 1'b0);
    endtask

    task automatic test_loopback();
        loopback = 1'b1;
        load_pair(8'hc3, 8'h5e);
        check_written();
        repeat (8) begin
            load_pair(byte_t'($random(seed)), byte_t'($random(seed)));
        end
        check_written();
    endtask

    task automatic test_txe_hold();
        @(negedge clock);
        txe_hold = 1'b1;
        load_pair(8'h11, 8'h22);
        load_pair(8'h33, 8'h44);
        wait_reads_done();
        // Long enough for the second frame to come back
        repeat (200) begin
            @(negedge clock);
            compare_bit("ftdi_wr", ftdi_wr, 1'b1);
        end
        txe_hold = 1'b0;
        check_written();
    endtask

    task automatic test_direct_frames();
        byte_t byte1;
        byte_t byte2;
        @(negedge clock);
        loopback = 1'b0;
        expected.push_back(8'ha5);
        expected.push_back(8'h3c);
        drive_frames(8'ha5, 8'h3c, 1'b0, -1);
        check_written();
        // Lane 2 stop bit high, whole pair dropped
        drive_frames(8'h0f, 8'hf0, 1'b1, -1);
        check_written();
        // One bad sample out of three voted ones still gives the sent bit
        for (int bad = 0; bad < `BIT_CYCLES; bad++) begin
            byte1 = byte_t'($random(seed));
            byte2 = byte_t'($random(seed));
            expected.push_back(byte1);
            expected.push_back(byte2);
            drive_frames(byte1, byte2, 1'b0, bad);
            check_written();
        end
    endtask

    initial begin
        reset = 1'b1;
        rxf = 1'b1;
        txe = 1'b0;
        adbus_in = 8'h00;
        laser1_rx = 1'b0;
        laser2_rx = 1'b0;
        pop_due = 1'b0;
        wr_setup = 1'b0;
        setup_byte = 8'h00;
        txe_hold = 1'b0;
        loopback = 1'b1;
        drive1 = 1'b0;
        drive2 = 1'b0;
        seed = 32'h5a3acb57;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        test_reset_state();
        test_loopback();
        test_txe_hold();
        test_direct_frames();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/laser_pkg.sv
hw/link_pkg.sv
hw/bit_timer.sv
hw/laser_serializer.sv
hw/laser_deserializer.sv
hw/rx_byte_queue.sv
hw/link_controller.sv
hw/laser_link.sv
test/laser_link_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the laser link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module laser_link_tb \
    -f flist.f -o sim_laser_link
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_laser_link > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
